//--- include/qspi_consts.svh
// ##################
// quad-SPI controller constants, shared by RTL, model and testbench
// ##################

`ifndef QSPI_CONSTS_SVH
`define QSPI_CONSTS_SVH

// clk cycles per SCK half-period, minus one
`define QSPI_SCK_HALF 32'd8

// flash commands
`define QSPI_CMD_FREADQ 8'hEB
`define QSPI_CMD_QWRITE 8'h38

// SCK cycles between address and read data
`define QSPI_DUMMY_CYC 8

// 24-bit address, one nibble per SCK
`define QSPI_ADR_NIBBLES 6

// request queue entries
`define QSPI_QUEUE_DEPTH 2

`endif

//--- src/qspi_pkg.sv
// ##################
// enums shared by the quad-SPI controller blocks
// ##################

`default_nettype none

package qspi_pkg;

	// serial engine phases
	typedef enum logic [2:0] {
		IDLE,
		CMD,
		ADR,
		WR_DATA,
		RD_WAIT,
		RD_DATA
	} qspi_state_e;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} mem_op_e;

	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD
	} acc_size_e;

endpackage

`default_nettype wire

//--- src/qspi_host_port.sv
// ##################
// CPU side of the controller, turns strobes into queue entries
// and engine completions back into CPU strobes
// ##################

`default_nettype none

module qspi_host_port (
	input wire clk,
	input wire rst_n,
	input wire req,
	input wire qspi_pkg::mem_op_e req_op,
	input wire qspi_pkg::acc_size_e req_size,
	input wire [31:0] req_adr,
	input wire [31:0] req_wdata,
	output logic push,
	output qspi_pkg::mem_op_e push_op,
	output qspi_pkg::acc_size_e push_size,
	output logic [23:0] push_adr,
	output logic [31:0] push_wdata,
	input wire done,
	input wire qspi_pkg::mem_op_e done_op,
	input wire [31:0] rd_word,
	output logic rd_valid,
	output logic [31:0] rd_data,
	output logic wr_done
);

	// lowest-address byte goes out first, so it lands in the top used byte
	function automatic logic [31:0] wire_order(input logic [31:0] d,
			input qspi_pkg::acc_size_e sz);
		case (sz)
			qspi_pkg::SZ_BYTE: wire_order = {24'd0, d[7:0]};
			qspi_pkg::SZ_HALF: wire_order = {16'd0, d[7:0], d[15:8]};
			default: wire_order = {d[7:0], d[15:8], d[23:16], d[31:24]};
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			push <= 1'b0;
		else
			push <= req;
	end

	always_ff @(posedge clk) begin
		if (req) begin
			push_op <= req_op;
			push_size <= req_size;
			push_adr <= req_adr[23:0];
			push_wdata <= wire_order(req_wdata, req_size);
		end
	end

	// engine returns the read word left-aligned in wire order
	assign rd_data = {rd_word[7:0], rd_word[15:8], rd_word[23:16], rd_word[31:24]};
	assign rd_valid = done && (done_op == qspi_pkg::OP_READ);
	assign wr_done = done && (done_op == qspi_pkg::OP_WRITE);

	a_req_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> req_size inside {qspi_pkg::SZ_BYTE, qspi_pkg::SZ_HALF, qspi_pkg::SZ_WORD})
		else $error("illegal access size on request");

endmodule

`default_nettype wire

//--- src/qspi_req_queue.sv
// ##################
// small circular request buffer, host port in, engine out
// ##################

`default_nettype none

`include "qspi_consts.svh"

module qspi_req_queue (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire qspi_pkg::mem_op_e push_op,
	input wire qspi_pkg::acc_size_e push_size,
	input wire [23:0] push_adr,
	input wire [31:0] push_wdata,
	input wire pop,
	output logic q_valid,
	output qspi_pkg::mem_op_e q_op,
	output qspi_pkg::acc_size_e q_size,
	output logic [23:0] q_adr,
	output logic [31:0] q_wdata,
	output logic full
);

	localparam int DEPTH = `QSPI_QUEUE_DEPTH;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	qspi_pkg::mem_op_e op_mem [DEPTH];
	qspi_pkg::acc_size_e size_mem [DEPTH];
	logic [23:0] adr_mem [DEPTH];
	logic [31:0] wdata_mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// strobe into a full queue is lost
	assign do_push = push && !full;
	assign do_pop = pop && q_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr] <= push_op;
			size_mem[wr_ptr] <= push_size;
			adr_mem[wr_ptr] <= push_adr;
			wdata_mem[wr_ptr] <= push_wdata;
		end
	end

	assign q_valid = (count != '0);
	assign full = (count == CW'(DEPTH));
	assign q_op = op_mem[rd_ptr];
	assign q_size = size_mem[rd_ptr];
	assign q_adr = adr_mem[rd_ptr];
	assign q_wdata = wdata_mem[rd_ptr];

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
		else $error("CPU request while queue full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> q_valid)
		else $error("engine pop from empty queue");

endmodule

`default_nettype wire

//--- src/qspi_sck_gen.sv
// ##################
// SCK divider with edge strobes, plus SIO input synchronizer
// ##################

`default_nettype none

`include "qspi_consts.svh"

module qspi_sck_gen (
	input wire clk,
	input wire rst_n,
	input wire [3:0] sio_in,
	output logic sck,
	output logic fall_edge,
	output logic rise_edge,
	output logic [3:0] sio_sync
);

	localparam logic [7:0] HALF = 8'(`QSPI_SCK_HALF);

	logic [7:0] div_cnt;
	logic sck_d;
	logic [3:0] sio_mt0;
	logic [3:0] sio_mt1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sck <= 1'b1;
			sck_d <= 1'b1;
		end else begin
			sck_d <= sck;
			if (div_cnt == HALF) begin
				div_cnt <= '0;
				sck <= ~sck;
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	// one clk wide, a cycle after SCK moves
	assign rise_edge = sck && !sck_d;
	assign fall_edge = !sck && sck_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_mt0 <= '0;
			sio_mt1 <= '0;
			sio_sync <= '0;
		end else begin
			sio_mt0 <= sio_in;
			sio_mt1 <= sio_mt0;
			sio_sync <= sio_mt1;
		end
	end

endmodule

`default_nettype wire

//--- src/qspi_engine.sv
// ##################
// serial engine, runs one queued request at a time on CE_N and SIO
// command on SIO0, then address, then write data or dummy plus read data
// ##################

`default_nettype none

`include "qspi_consts.svh"

module qspi_engine (
	input wire clk,
	input wire rst_n,
	input wire fall_edge,
	input wire rise_edge,
	input wire [3:0] sio_sync,
	input wire q_valid,
	input wire qspi_pkg::mem_op_e q_op,
	input wire qspi_pkg::acc_size_e q_size,
	input wire [23:0] q_adr,
	input wire [31:0] q_wdata,
	output logic pop,
	output logic ce_n,
	output logic [3:0] sio_out,
	output logic sio_oe,
	output logic done,
	output qspi_pkg::mem_op_e done_op,
	output logic [31:0] rd_word
);

	localparam logic [2:0] ADR_LAST = 3'(`QSPI_ADR_NIBBLES - 1);
	localparam logic [2:0] WAIT_LAST = 3'(`QSPI_DUMMY_CYC - 1);

	// last nibble index of the data phase
	function automatic logic [2:0] nib_last(input qspi_pkg::acc_size_e sz);
		case (sz)
			qspi_pkg::SZ_BYTE: nib_last = 3'd1;
			qspi_pkg::SZ_HALF: nib_last = 3'd3;
			default: nib_last = 3'd7;
		endcase
	endfunction

	qspi_pkg::qspi_state_e state;
	qspi_pkg::qspi_state_e state_nx;

	qspi_pkg::mem_op_e op_r;
	qspi_pkg::acc_size_e size_r;
	logic [23:0] adr_r;
	logic [31:0] wdata_r;
	logic [31:0] rd_sh;

	logic [2:0] cmd_cnt;
	logic [2:0] adr_cnt;
	logic [2:0] wait_cnt;
	logic [2:0] data_cnt;

	logic take;
	logic data_end;
	logic [7:0] cmd_byte;
	logic [3:0] sio_nx;
	logic [4:0] rd_shift;

	always_comb begin
		state_nx = state;
		case (state)
			qspi_pkg::IDLE:
				if (q_valid)
					state_nx = qspi_pkg::CMD;
			qspi_pkg::CMD:
				if (cmd_cnt == 3'd0)
					state_nx = qspi_pkg::ADR;
			qspi_pkg::ADR:
				if (adr_cnt == 3'd0)
					state_nx = (op_r == qspi_pkg::OP_READ) ? qspi_pkg::RD_WAIT :
						qspi_pkg::WR_DATA;
			qspi_pkg::RD_WAIT:
				if (wait_cnt == 3'd0)
					state_nx = qspi_pkg::RD_DATA;
			qspi_pkg::WR_DATA, qspi_pkg::RD_DATA:
				if (data_cnt == 3'd0)
					state_nx = qspi_pkg::IDLE;
			default: state_nx = qspi_pkg::IDLE;
		endcase
	end

	assign take = fall_edge && (state == qspi_pkg::IDLE) && q_valid;
	assign data_end = fall_edge && (data_cnt == 3'd0) &&
		(state == qspi_pkg::WR_DATA || state == qspi_pkg::RD_DATA);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= qspi_pkg::IDLE;
			pop <= 1'b0;
			done <= 1'b0;
		end else begin
			if (fall_edge)
				state <= state_nx;
			// head leaves the queue one clk after capture
			pop <= take;
			done <= data_end;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			op_r <= q_op;
			size_r <= q_size;
			adr_r <= q_adr;
			wdata_r <= q_wdata;
		end
	end

	// each counter holds its start value outside its own phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_cnt <= 3'd7;
			adr_cnt <= ADR_LAST;
			wait_cnt <= WAIT_LAST;
			data_cnt <= 3'd7;
		end else if (fall_edge) begin
			cmd_cnt <= (state == qspi_pkg::CMD) ? cmd_cnt - 3'd1 : 3'd7;
			adr_cnt <= (state == qspi_pkg::ADR) ? adr_cnt - 3'd1 : ADR_LAST;
			wait_cnt <= (state == qspi_pkg::RD_WAIT) ? wait_cnt - 3'd1 : WAIT_LAST;
			if (state == qspi_pkg::WR_DATA || state == qspi_pkg::RD_DATA)
				data_cnt <= data_cnt - 3'd1;
			else
				data_cnt <= nib_last(size_r);
		end
	end

	assign cmd_byte = (op_r == qspi_pkg::OP_READ) ? `QSPI_CMD_FREADQ : `QSPI_CMD_QWRITE;

	always_comb begin
		case (state)
			qspi_pkg::CMD: sio_nx = {3'b000, cmd_byte[cmd_cnt]};
			qspi_pkg::ADR: sio_nx = adr_r[{adr_cnt, 2'b00} +: 4];
			qspi_pkg::WR_DATA: sio_nx = wdata_r[{data_cnt, 2'b00} +: 4];
			default: sio_nx = 4'h0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ce_n <= 1'b1;
			sio_out <= 4'h0;
			sio_oe <= 1'b0;
		end else begin
			ce_n <= (state == qspi_pkg::IDLE);
			sio_out <= sio_nx;
			sio_oe <= (state == qspi_pkg::CMD) || (state == qspi_pkg::ADR) ||
				(state == qspi_pkg::WR_DATA);
		end
	end

	// cleared during the dummy cycles, first nibble ends up on top
	always_ff @(posedge clk) begin
		if (fall_edge && state == qspi_pkg::RD_WAIT)
			rd_sh <= 32'd0;
		else if (rise_edge && state == qspi_pkg::RD_DATA)
			rd_sh <= {rd_sh[27:0], sio_sync};
	end

	always_comb begin
		case (size_r)
			qspi_pkg::SZ_BYTE: rd_shift = 5'd24;
			qspi_pkg::SZ_HALF: rd_shift = 5'd16;
			default: rd_shift = 5'd0;
		endcase
	end

	assign rd_word = rd_sh << rd_shift;
	assign done_op = op_r;

	a_no_drive_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		(state == qspi_pkg::RD_DATA || (state == qspi_pkg::RD_WAIT && rise_edge)) |-> !sio_oe)
		else $error("SIO driven while the memory owns the bus");
	a_ce_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == qspi_pkg::IDLE && fall_edge) |-> ce_n)
		else $error("CE_N low with engine idle");

endmodule

`default_nettype wire

//--- src/qspi_ctrl_top.sv
// ##################
// quad-SPI controller top, CPU strobe port in, flash pins out
// ##################

`default_nettype none

module qspi_ctrl_top (
	input wire clk,
	input wire rst_n,
	input wire req,
	input wire qspi_pkg::mem_op_e req_op,
	input wire qspi_pkg::acc_size_e req_size,
	input wire [31:0] req_adr,
	input wire [31:0] req_wdata,
	output logic rd_valid,
	output logic [31:0] rd_data,
	output logic wr_done,
	output logic busy,
	output logic full,
	output logic sck,
	output logic ce_n,
	inout wire [3:0] sio
);

	logic push;
	qspi_pkg::mem_op_e push_op;
	qspi_pkg::acc_size_e push_size;
	logic [23:0] push_adr;
	logic [31:0] push_wdata;

	logic pop;
	logic q_valid;
	qspi_pkg::mem_op_e q_op;
	qspi_pkg::acc_size_e q_size;
	logic [23:0] q_adr;
	logic [31:0] q_wdata;

	logic fall_edge;
	logic rise_edge;
	logic [3:0] sio_sync;
	logic [3:0] sio_out;
	logic sio_oe;

	logic done;
	qspi_pkg::mem_op_e done_op;
	logic [31:0] rd_word;

	// SIO pad, released during dummy and read data
	assign sio = sio_oe ? sio_out : 4'hz;

	assign busy = q_valid || !ce_n;

	qspi_host_port i_host_port (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_op(req_op), .req_size(req_size),
		.req_adr(req_adr), .req_wdata(req_wdata),
		.push(push), .push_op(push_op), .push_size(push_size),
		.push_adr(push_adr), .push_wdata(push_wdata),
		.done(done), .done_op(done_op), .rd_word(rd_word),
		.rd_valid(rd_valid), .rd_data(rd_data), .wr_done(wr_done)
	);

	qspi_req_queue i_req_queue (
		.clk(clk), .rst_n(rst_n),
		.push(push), .push_op(push_op), .push_size(push_size),
		.push_adr(push_adr), .push_wdata(push_wdata),
		.pop(pop), .q_valid(q_valid), .q_op(q_op), .q_size(q_size),
		.q_adr(q_adr), .q_wdata(q_wdata), .full(full)
	);

	qspi_sck_gen i_sck_gen (
		.clk(clk), .rst_n(rst_n), .sio_in(sio),
		.sck(sck), .fall_edge(fall_edge), .rise_edge(rise_edge),
		.sio_sync(sio_sync)
	);

	qspi_engine i_engine (
		.clk(clk), .rst_n(rst_n),
		.fall_edge(fall_edge), .rise_edge(rise_edge), .sio_sync(sio_sync),
		.q_valid(q_valid), .q_op(q_op), .q_size(q_size),
		.q_adr(q_adr), .q_wdata(q_wdata), .pop(pop),
		.ce_n(ce_n), .sio_out(sio_out), .sio_oe(sio_oe),
		.done(done), .done_op(done_op), .rd_word(rd_word)
	);

endmodule

`default_nettype wire

//--- verif/qspi_mem_model.sv
// ####################
// behavioral quad-SPI flash with 256 bytes, quad write and fast quad read
// ####################

`default_nettype none

`include "qspi_consts.svh"

module qspi_mem_model (
	input wire sck,
	input wire ce_n,
	inout wire [3:0] sio
);
	timeunit 1ns;
	timeprecision 1ps;

	// rising SCK edges until the address is complete, then until read data starts
	localparam int ADR_END = 8 + `QSPI_ADR_NIBBLES;
	localparam int RD_START = ADR_END + `QSPI_DUMMY_CYC;

	logic [7:0] mem [256];
	logic [7:0] cmd;
	logic [23:0] adr;
	logic [3:0] hi_nib;
	logic [3:0] drv_nib;
	logic [7:0] rd_byte;
	logic drv_en = 1'b0;
	int rise_cnt = 0;
	int nib;
	int cmd_errors = 0;

	assign sio = drv_en ? drv_nib : 4'hz;

	// command, address and write nibbles all come in on rising SCK
	always @(posedge sck or posedge ce_n) begin
		if (ce_n) begin
			rise_cnt <= 0;
		end else begin
			rise_cnt <= rise_cnt + 1;
			if (rise_cnt < 8) begin
				cmd <= {cmd[6:0], sio[0]};
			end else if (rise_cnt < ADR_END) begin
				adr <= {adr[19:0], sio};
				if (rise_cnt == 8 && cmd != `QSPI_CMD_FREADQ && cmd != `QSPI_CMD_QWRITE) begin
					cmd_errors <= cmd_errors + 1;
					$display("memory model received unknown command %h", cmd);
				end
			end else if (cmd == `QSPI_CMD_QWRITE) begin
				// high nibble first, bytes at rising addresses
				if (((rise_cnt - ADR_END) % 2) == 0)
					hi_nib <= sio;
				else
					mem[8'(adr[7:0] + 8'((rise_cnt - ADR_END) / 2))] <= {hi_nib, sio};
			end
		end
	end

	// read data goes out on falling SCK once the dummy cycles are over
	always @(negedge sck or posedge ce_n) begin
		if (ce_n) begin
			drv_en <= 1'b0;
		end else if (cmd == `QSPI_CMD_FREADQ && rise_cnt >= RD_START) begin
			nib = rise_cnt - RD_START;
			rd_byte = mem[8'(adr[7:0] + 8'(nib / 2))];
			drv_en <= 1'b1;
			drv_nib <= nib[0] ? rd_byte[3:0] : rd_byte[7:4];
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_qspi_ctrl.sv
// ####################
// directed tests for the quad-SPI controller against a behavioral flash
// ####################

`default_nettype none

`include "qspi_consts.svh"

module tb_qspi_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	// about 60 transactions of at most 30 SCK periods, plus margin
	localparam int SCK_CYC = 2 * (`QSPI_SCK_HALF + 1);
	localparam int TIMEOUT_CYC = 60 * 30 * SCK_CYC + 7600;
	localparam int WAIT_CYC = `QSPI_QUEUE_DEPTH * 30 * SCK_CYC + 100;

	logic clk;
	logic rst_n;
	logic req;
	qspi_pkg::mem_op_e req_op;
	qspi_pkg::acc_size_e req_size;
	logic [31:0] req_adr;
	logic [31:0] req_wdata;
	wire rd_valid;
	wire [31:0] rd_data;
	wire wr_done;
	wire busy;
	wire full;
	wire sck;
	wire ce_n;
	wire [3:0] sio;

	logic [7:0] ref_mem [256];
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	pullup (sio[0]);
	pullup (sio[1]);
	pullup (sio[2]);
	pullup (sio[3]);

	qspi_ctrl_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_op(req_op), .req_size(req_size),
		.req_adr(req_adr), .req_wdata(req_wdata),
		.rd_valid(rd_valid), .rd_data(rd_data), .wr_done(wr_done),
		.busy(busy), .full(full), .sck(sck), .ce_n(ce_n), .sio(sio)
	);

	qspi_mem_model i_mem (.sck(sck), .ce_n(ce_n), .sio(sio));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == TIMEOUT_CYC) begin
			$display("timeout, run exceeded %0d clk cycles", TIMEOUT_CYC);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s expected %h got %h", name, exp, got);
		end
	endtask

	function automatic int nbytes(input qspi_pkg::acc_size_e sz);
		return (sz == qspi_pkg::SZ_BYTE) ? 1 : (sz == qspi_pkg::SZ_HALF) ? 2 : 4;
	endfunction

	// little-endian, zero-extended
	function automatic logic [31:0] expect_read(input logic [7:0] adr,
			input qspi_pkg::acc_size_e sz);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < nbytes(sz); i++)
			v[8*i +: 8] = ref_mem[8'(adr + i)];
		return v;
	endfunction

	task automatic fill_memory();
		logic [7:0] v;
		for (int i = 0; i < 256; i++) begin
			v = 8'(i * 37 + 11);
			ref_mem[i] = v;
			i_mem.mem[i] = v;
		end
	endtask

	// one-cycle strobe, entered and left on a falling clk edge
	task automatic issue(input qspi_pkg::mem_op_e op, input qspi_pkg::acc_size_e sz,
			input logic [7:0] adr, input logic [31:0] wdata);
		req = 1'b1;
		req_op = op;
		req_size = sz;
		req_adr = {24'd0, adr};
		req_wdata = wdata;
		@(negedge clk);
		req = 1'b0;
		if (op == qspi_pkg::OP_WRITE) begin
			for (int i = 0; i < nbytes(sz); i++)
				ref_mem[8'(adr + i)] = wdata[8*i +: 8];
		end
	endtask

	task automatic wait_completion(output logic was_read, output logic [31:0] data);
		int n;
		n = 0;
		was_read = 1'b0;
		data = 32'd0;
		while (!rd_valid && !wr_done && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (n >= WAIT_CYC) begin
			errors++;
			$display("no completion strobe within %0d clk cycles", WAIT_CYC);
		end else begin
			was_read = rd_valid;
			data = rd_data;
			@(negedge clk);
		end
	endtask

	task automatic access(input qspi_pkg::mem_op_e op, input qspi_pkg::acc_size_e sz,
			input logic [7:0] adr, input logic [31:0] wdata);
		logic [31:0] exp;
		logic was_read;
		logic [31:0] got;
		exp = expect_read(adr, sz);
		issue(op, sz, adr, wdata);
		wait_completion(was_read, got);
		check("rd_valid", op == qspi_pkg::OP_READ, was_read);
		if (op == qspi_pkg::OP_READ)
			check("rd_data", exp, got);
		check("busy", 1'b0, busy);
	endtask

	task automatic after_reset();
		check("ce_n", 1'b1, ce_n);
		check("sck", 1'b1, sck);
		check("sio", 4'hf, sio);
		check("rd_valid", 1'b0, rd_valid);
		check("wr_done", 1'b0, wr_done);
		check("busy", 1'b0, busy);
		check("full", 1'b0, full);
	endtask

	task automatic word_round_trip();
		logic [31:0] w;
		w = $urandom;
		access(qspi_pkg::OP_WRITE, qspi_pkg::SZ_WORD, 8'h40, w);
		access(qspi_pkg::OP_READ, qspi_pkg::SZ_WORD, 8'h40, 32'd0);
		for (int i = 0; i < 4; i++)
			check("mem_model mem", w[8*i +: 8], i_mem.mem[8'(8'h40 + i)]);
	endtask

	task automatic narrow_accesses();
		// unused upper write bits must not reach the memory
		access(qspi_pkg::OP_WRITE, qspi_pkg::SZ_BYTE, 8'h81, 32'hffff_ff5a);
		access(qspi_pkg::OP_WRITE, qspi_pkg::SZ_HALF, 8'h82, 32'hdead_c3b7);
		access(qspi_pkg::OP_WRITE, qspi_pkg::SZ_BYTE, 8'h80, $urandom);
		access(qspi_pkg::OP_WRITE, qspi_pkg::SZ_HALF, 8'h85, $urandom);
		access(qspi_pkg::OP_READ, qspi_pkg::SZ_WORD, 8'h80, 32'd0);
		access(qspi_pkg::OP_READ, qspi_pkg::SZ_WORD, 8'h84, 32'd0);
		access(qspi_pkg::OP_READ, qspi_pkg::SZ_BYTE, 8'h83, 32'd0);
		access(qspi_pkg::OP_READ, qspi_pkg::SZ_HALF, 8'h81, 32'd0);
	endtask

	task automatic back_to_back();
		logic [31:0] w;
		logic was_read;
		logic [31:0] got;
		w = $urandom;
		issue(qspi_pkg::OP_WRITE, qspi_pkg::SZ_WORD, 8'hc0, w);
		issue(qspi_pkg::OP_READ, qspi_pkg::SZ_WORD, 8'hc0, 32'd0);
		check("full", 1'b0, full);
		@(negedge clk);
		check("full", 1'b1, full);
		wait_completion(was_read, got);
		check("rd_valid", 1'b0, was_read);
		wait_completion(was_read, got);
		check("rd_valid", 1'b1, was_read);
		check("rd_data", w, got);
		check("busy", 1'b0, busy);
	endtask

	task automatic random_traffic(input int count);
		qspi_pkg::mem_op_e op;
		qspi_pkg::acc_size_e sz;
		for (int n = 0; n < count; n++) begin
			op = qspi_pkg::mem_op_e'($urandom % 2);
			sz = qspi_pkg::acc_size_e'($urandom % 3);
			access(op, sz, 8'($urandom % 256), $urandom);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		req = 1'b0;
		req_op = qspi_pkg::OP_READ;
		req_size = qspi_pkg::SZ_BYTE;
		req_adr = 32'd0;
		req_wdata = 32'd0;
		void'($urandom(32'hab08));
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		after_reset();
		fill_memory();
		word_round_trip();
		narrow_accesses();
		back_to_back();
		random_traffic(40);
		check("mem_model cmd_errors", 32'd0, i_mem.cmd_errors);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/qspi_pkg.sv
src/qspi_host_port.sv
src/qspi_req_queue.sv
src/qspi_sck_gen.sv
src/qspi_engine.sv
src/qspi_ctrl_top.sv
verif/qspi_mem_model.sv
verif/tb_qspi_ctrl.sv

//--- Makefile
# Verilator build and run of the quad-SPI controller testbench

VERILATOR ?= verilator
TOP ?= tb_qspi_ctrl
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
